// ==== rtl/pic_bus_pkg.sv ====
`default_nettype none

package pic_bus_pkg;

	// ====================================================================
	// register port types
	// ====================================================================

	typedef logic [31:0] pic_addr_t;
	typedef logic [31:0] pic_data_t;

	// word offset within the page, byte address bits 7..2
	typedef logic [5:0] reg_offs_t;

	// one register request, valid while the strobe is high
	typedef struct packed {
		logic      we;
		pic_addr_t addr;
		pic_data_t wdata;
	} bus_req_t;

	// ====================================================================
	// word offsets
	// ====================================================================

	localparam reg_offs_t REG_CAUSE       = 6'd0;
	localparam reg_offs_t REG_ENABLE      = 6'd1;
	localparam reg_offs_t REG_DISABLE_NUM = 6'd2;
	localparam reg_offs_t REG_ENABLE_NUM  = 6'd3;
	localparam reg_offs_t REG_EDGE_SEL    = 6'd4;
	localparam reg_offs_t REG_CLEAR_EDGE  = 6'd5;
	localparam reg_offs_t REG_TRIGGER     = 6'd6;
	// offsets 32..63 hold the per-line control words

endpackage

`default_nettype wire

// ==== rtl/pic_edge_capture.sv ====
`default_nettype none

module pic_edge_capture #(
	parameter int unsigned NUM_IRQ = 32
) (
	input wire clk,
	input wire rst_i,
	input wire [NUM_IRQ-1:0] irq_lines_i,
	input wire [NUM_IRQ-1:0] edge_sel_i,
	input wire [NUM_IRQ-1:0] clear_edge_i,
	input wire [NUM_IRQ-1:0] trigger_i,
	output logic [NUM_IRQ-1:0] pending_o
);
	// previous sample of each line
	logic [NUM_IRQ-1:0] prev_q;
	// edge latch per line
	logic [NUM_IRQ-1:0] latch_q;
	logic [NUM_IRQ-1:0] latch_d;
	logic [NUM_IRQ-1:0] pend_d;

	// rising edge or software trigger sets the latch
	// a clear in the same cycle wins
	assign latch_d = (latch_q | (irq_lines_i & ~prev_q) | trigger_i) & ~clear_edge_i;

	// edge lines use the updated latch so a new edge is pending at once
	// level lines pass the sample straight through
	assign pend_d = (edge_sel_i & latch_d) | (~edge_sel_i & irq_lines_i);

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			prev_q <= '0;
			latch_q <= '0;
			pending_o <= '0;
		end
		else
		begin
			prev_q <= irq_lines_i;
			latch_q <= latch_d;
			// line 0 is the nmi and never goes to the encoder
			pending_o <= {pend_d[NUM_IRQ-1:1], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pic_irq_output.sv ====
`default_nettype none

module pic_irq_output #(
	parameter int unsigned NUM_IRQ = 32
) (
	input wire clk,
	input wire rst_i,
	input wire pic_irq_pkg::irq_id_t cur_id_i,
	input wire [NUM_IRQ-1:0] enable_i,
	input wire pic_irq_pkg::irq_ctrl_t [NUM_IRQ-1:0] ctrl_i,
	input wire nmi_i,
	output pic_irq_pkg::irq_level_t irq_level_o,
	output pic_irq_pkg::irq_cause_t irq_cause_o,
	output logic nmi_o
);
	import pic_irq_pkg::*;

	// control word and enable bit of the encoded line
	irq_ctrl_t sel_ctrl;
	logic sel_en;

	assign sel_ctrl = ctrl_i[cur_id_i];
	assign sel_en = enable_i[cur_id_i];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			irq_level_o <= '0;
			irq_cause_o <= '0;
			nmi_o <= 1'b0;
		end
		else
		begin
			if (cur_id_i == '0)
			begin
				// no maskable request
				irq_level_o <= '0;
				irq_cause_o <= '0;
			end
			else
			begin
				// disabled line still shows its cause, level drops to 0
				irq_level_o <= sel_en ? sel_ctrl.level : '0;
				irq_cause_o <= sel_ctrl.cause;
			end
			// enable bit 0 gates the nmi
			nmi_o <= nmi_i & enable_i[0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pic_irq_pkg.sv ====
`default_nettype none

package pic_irq_pkg;

	// ====================================================================
	// interrupt line types
	// ====================================================================

	// line number, 0 is the non-maskable line
	typedef logic [4:0] irq_id_t;

	// priority level presented to the processor, 0 means no request
	typedef logic [3:0] irq_level_t;

	// cause code handed to the processor with the level
	typedef logic [7:0] irq_cause_t;

	// per-line control word
	// level above cause so the packed value matches register bits 11..0
	typedef struct packed {
		irq_level_t level;
		irq_cause_t cause;
	} irq_ctrl_t;

	// ====================================================================
	// reset defaults
	// ====================================================================

	localparam irq_ctrl_t CTRL_RESET = '{level: 4'd8, cause: 8'd0};

	// every line starts in edge mode
	localparam logic [31:0] EDGE_SEL_RESET = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== rtl/pic_prio_encoder.sv ====
`default_nettype none

module pic_prio_encoder #(
	parameter int unsigned NUM_IRQ = 32
) (
	input wire clk,
	input wire rst_i,
	input wire [NUM_IRQ-1:0] pending_i,
	output pic_irq_pkg::irq_id_t cur_id_o
);
	import pic_irq_pkg::*;

	// highest pending line number, 0 when nothing pending
	irq_id_t top_id;

	// ====================================================================
	// priority encode
	// ====================================================================

	// ascending scan, the last hit is the highest line
	// bit 0 is skipped since the nmi is handled apart
	always_comb
	begin
		top_id = '0;
		for (int n = 1; n < NUM_IRQ; n++)
		begin
			if (pending_i[n])
				top_id = irq_id_t'(n);
		end
	end

	// register the result, stage 2 of the request path
	always_ff @(posedge clk)
	begin
		if (rst_i)
			cur_id_o <= '0;
		else
			cur_id_o <= top_id;
	end

endmodule

`default_nettype wire

// ==== rtl/pic_regfile.sv ====
`default_nettype none

module pic_regfile #(
	parameter int unsigned NUM_IRQ = 32,
	parameter logic [31:0] BASE_ADDR = 32'hFF95_0000
) (
	input wire clk,
	input wire rst_i,
	input wire req_i,
	input wire pic_bus_pkg::bus_req_t req_data_i,
	input wire pic_irq_pkg::irq_id_t cur_id_i,
	output pic_bus_pkg::pic_data_t rdata_o,
	output logic rvalid_o,
	output logic [NUM_IRQ-1:0] enable_o,
	output logic [NUM_IRQ-1:0] edge_sel_o,
	output logic [NUM_IRQ-1:0] clear_edge_o,
	output logic [NUM_IRQ-1:0] trigger_o,
	output pic_irq_pkg::irq_ctrl_t [NUM_IRQ-1:0] ctrl_o
);
	import pic_bus_pkg::*;
	import pic_irq_pkg::*;

	logic page_hit;
	logic wr_hit;
	logic rd_hit;
	reg_offs_t offs;
	// line addressed by a control word offset
	irq_id_t ctrl_line;
	// line named in write data bits 4..0
	irq_id_t data_line;
	logic ctrl_ok;
	logic data_ok;

	logic [NUM_IRQ-1:0] enable_q;
	logic [NUM_IRQ-1:0] edge_sel_q;
	irq_ctrl_t [NUM_IRQ-1:0] ctrl_q;

	// ====================================================================
	// request decode
	// ====================================================================

	// only the 4 KB page of BASE_ADDR answers
	assign page_hit = req_i && (req_data_i.addr[31:12] == BASE_ADDR[31:12]);
	assign wr_hit = page_hit && req_data_i.we;
	assign rd_hit = page_hit && !req_data_i.we;
	assign offs = req_data_i.addr[7:2];
	assign ctrl_line = req_data_i.addr[6:2];
	assign data_line = req_data_i.wdata[4:0];
	// lines above NUM_IRQ-1 do not exist
	assign ctrl_ok = 32'(ctrl_line) < NUM_IRQ;
	assign data_ok = 32'(data_line) < NUM_IRQ;

	// ====================================================================
	// register writes
	// ====================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			enable_q <= '0;
			edge_sel_q <= EDGE_SEL_RESET[NUM_IRQ-1:0];
			ctrl_q <= {NUM_IRQ{CTRL_RESET}};
			clear_edge_o <= '0;
			trigger_o <= '0;
		end
		else
		begin
			// clear and trigger are one-cycle pulses
			clear_edge_o <= '0;
			trigger_o <= '0;
			if (wr_hit && offs[5])
			begin
				// control word also carries the enable and edge-select bits
				if (ctrl_ok)
				begin
					ctrl_q[ctrl_line] <= req_data_i.wdata[11:0];
					enable_q[ctrl_line] <= req_data_i.wdata[16];
					edge_sel_q[ctrl_line] <= req_data_i.wdata[17];
				end
			end
			else if (wr_hit)
			begin
				case (offs)
				REG_ENABLE: enable_q <= req_data_i.wdata[NUM_IRQ-1:0];
				REG_DISABLE_NUM, REG_ENABLE_NUM:
					if (data_ok)
						enable_q[data_line] <= (offs == REG_ENABLE_NUM);
				REG_EDGE_SEL: edge_sel_q <= req_data_i.wdata[NUM_IRQ-1:0];
				REG_CLEAR_EDGE:
					if (data_ok)
						clear_edge_o[data_line] <= 1'b1;
				REG_TRIGGER:
					if (data_ok)
						trigger_o[data_line] <= 1'b1;
				// cause register is read only, other offsets unused
				default: ;
				endcase
			end
		end
	end

	// ====================================================================
	// register reads, data valid the cycle after the request
	// ====================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
			rvalid_o <= 1'b0;
		else
			rvalid_o <= rd_hit;
	end

	always_ff @(posedge clk)
	begin
		if (rd_hit && offs[5])
		begin
			// same layout as the control word write
			rdata_o <= '0;
			if (ctrl_ok)
			begin
				rdata_o[11:0] <= ctrl_q[ctrl_line];
				rdata_o[16] <= enable_q[ctrl_line];
				rdata_o[17] <= edge_sel_q[ctrl_line];
			end
		end
		else if (rd_hit)
		begin
			case (offs)
			REG_CAUSE:
				rdata_o <= (cur_id_i == '0) ? '0 : pic_data_t'(ctrl_q[cur_id_i].cause);
			REG_EDGE_SEL: rdata_o <= pic_data_t'(edge_sel_q);
			default: rdata_o <= pic_data_t'(enable_q);
			endcase
		end
	end

	assign enable_o = enable_q;
	assign edge_sel_o = edge_sel_q;
	assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// ==== rtl/pic_top.sv ====
`default_nettype none

module pic_top #(
	parameter int unsigned NUM_IRQ = 32,
	parameter logic [31:0] BASE_ADDR = 32'hFF95_0000
) (
	input wire clk,
	input wire rst_i,
	input wire req_i,
	input wire pic_bus_pkg::bus_req_t req_data_i,
	output pic_bus_pkg::pic_data_t rdata_o,
	output logic rvalid_o,
	input wire [NUM_IRQ-1:0] irq_lines_i,
	input wire nmi_i,
	output pic_irq_pkg::irq_level_t irq_level_o,
	output pic_irq_pkg::irq_cause_t irq_cause_o,
	output logic nmi_o
);
	import pic_irq_pkg::*;

	// configuration from the register block
	logic [NUM_IRQ-1:0] enable;
	logic [NUM_IRQ-1:0] edge_sel;
	logic [NUM_IRQ-1:0] clear_edge;
	logic [NUM_IRQ-1:0] trigger;
	irq_ctrl_t [NUM_IRQ-1:0] ctrl;

	// pipeline between the stages
	logic [NUM_IRQ-1:0] pending;
	irq_id_t cur_id;

	// ====================================================================
	// register block beside the pipeline
	// ====================================================================

	pic_regfile #(
		.NUM_IRQ(NUM_IRQ),
		.BASE_ADDR(BASE_ADDR)
	) u_regfile (
		.clk(clk),
		.rst_i(rst_i),
		.req_i(req_i),
		.req_data_i(req_data_i),
		.cur_id_i(cur_id),
		.rdata_o(rdata_o),
		.rvalid_o(rvalid_o),
		.enable_o(enable),
		.edge_sel_o(edge_sel),
		.clear_edge_o(clear_edge),
		.trigger_o(trigger),
		.ctrl_o(ctrl)
	);

	// ====================================================================
	// request path, capture then encode then output
	// ====================================================================

	pic_edge_capture #(
		.NUM_IRQ(NUM_IRQ)
	) u_capture (
		.clk(clk),
		.rst_i(rst_i),
		.irq_lines_i(irq_lines_i),
		.edge_sel_i(edge_sel),
		.clear_edge_i(clear_edge),
		.trigger_i(trigger),
		.pending_o(pending)
	);

	pic_prio_encoder #(
		.NUM_IRQ(NUM_IRQ)
	) u_encoder (
		.clk(clk),
		.rst_i(rst_i),
		.pending_i(pending),
		.cur_id_o(cur_id)
	);

	pic_irq_output #(
		.NUM_IRQ(NUM_IRQ)
	) u_output (
		.clk(clk),
		.rst_i(rst_i),
		.cur_id_i(cur_id),
		.enable_i(enable),
		.ctrl_i(ctrl),
		.nmi_i(nmi_i),
		.irq_level_o(irq_level_o),
		.irq_cause_o(irq_cause_o),
		.nmi_o(nmi_o)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module pic_tb -f src.f -o Vpic_tb

# the model may exit non-zero on failure, the log decides
./obj_dir/Vpic_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"

// ==== src.f ====
rtl/pic_bus_pkg.sv
rtl/pic_irq_pkg.sv
rtl/pic_regfile.sv
rtl/pic_edge_capture.sv
rtl/pic_prio_encoder.sv
rtl/pic_irq_output.sv
rtl/pic_top.sv
test/pic_assert.sv
test/pic_tb.sv

// ==== test/pic_assert.sv ====
`default_nettype none

module pic_assert #(
	parameter int unsigned NUM_IRQ = 32,
	parameter logic [31:0] BASE_ADDR = 32'hFF95_0000
) (
	input wire clk,
	input wire rst_i,
	input wire req_i,
	input wire pic_bus_pkg::bus_req_t req_data_i,
	input wire pic_bus_pkg::pic_data_t rdata_o,
	input wire rvalid_o,
	input wire [NUM_IRQ-1:0] irq_lines_i,
	input wire nmi_i,
	input wire pic_irq_pkg::irq_level_t irq_level_o,
	input wire pic_irq_pkg::irq_cause_t irq_cause_o,
	input wire nmi_o
);
	timeunit 1ns;
	timeprecision 100ps;

	import pic_bus_pkg::*;
	import pic_irq_pkg::*;

	// name of the running sequence, written by the testbench
	string test_name = "";
	logic fail_q = 1'b0;

	// ====================================================================
	// shadow of the configuration, rebuilt from the port requests
	// ====================================================================

	logic [NUM_IRQ-1:0] en_s;
	logic [NUM_IRQ-1:0] es_s;
	irq_level_t lvl_s [NUM_IRQ];
	irq_cause_t cause_s [NUM_IRQ];
	// edge latches, last line sample, clear and trigger one cycle late
	logic [NUM_IRQ-1:0] latch_s;
	logic [NUM_IRQ-1:0] prev_s;
	logic [NUM_IRQ-1:0] clr_s;
	logic [NUM_IRQ-1:0] trg_s;
	// edges since the last write or line change, saturating
	logic [2:0] quiet;
	logic wr_hit;
	logic rd_hit;
	reg_offs_t offs;
	irq_id_t line_n;
	irq_id_t exp_id;
	irq_level_t exp_level;
	irq_cause_t exp_cause;
	pic_data_t exp_rdata;
	// read seen last cycle, and whether its data can be predicted
	logic rd_seen;
	logic rd_chk;
	pic_data_t rd_exp;

	assign wr_hit = req_i && req_data_i.we && (req_data_i.addr[31:12] == BASE_ADDR[31:12]);
	assign rd_hit = req_i && !req_data_i.we && (req_data_i.addr[31:12] == BASE_ADDR[31:12]);
	assign offs = req_data_i.addr[7:2];
	assign line_n = req_data_i.wdata[4:0];

	always_comb
	begin
		// first pending line from the top, line 0 never counts
		exp_id = '0;
		for (int n = NUM_IRQ - 1; n > 0; n--)
		begin
			if (exp_id == '0 && (es_s[n] ? latch_s[n] : prev_s[n]))
				exp_id = irq_id_t'(n);
		end
		exp_level = (exp_id != '0 && en_s[exp_id]) ? lvl_s[exp_id] : '0;
		exp_cause = (exp_id != '0) ? cause_s[exp_id] : '0;
		if (offs[5])
			exp_rdata = {14'd0, es_s[offs[4:0]], en_s[offs[4:0]], 4'd0,
				lvl_s[offs[4:0]], cause_s[offs[4:0]]};
		else if (offs == REG_CAUSE)
			exp_rdata = {24'd0, exp_cause};
		else if (offs == REG_EDGE_SEL)
			exp_rdata = 32'(es_s);
		else
			exp_rdata = 32'(en_s);
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			en_s <= '0;
			es_s <= '1;
			latch_s <= '0;
			prev_s <= '0;
			clr_s <= '0;
			trg_s <= '0;
			quiet <= '0;
			rd_seen <= 1'b0;
			rd_chk <= 1'b0;
			rd_exp <= '0;
			for (int n = 0; n < NUM_IRQ; n++)
			begin
				lvl_s[n] <= 4'd8;
				cause_s[n] <= '0;
			end
		end
		else
		begin
			prev_s <= irq_lines_i;
			clr_s <= '0;
			trg_s <= '0;
			// rising edge or trigger sets, clear overrides
			latch_s <= ~clr_s & (latch_s | trg_s | (irq_lines_i & ~prev_s));
			if (wr_hit && offs[5])
			begin
				lvl_s[offs[4:0]] <= req_data_i.wdata[11:8];
				cause_s[offs[4:0]] <= req_data_i.wdata[7:0];
				en_s[offs[4:0]] <= req_data_i.wdata[16];
				es_s[offs[4:0]] <= req_data_i.wdata[17];
			end
			else if (wr_hit)
			begin
				case (offs)
				REG_ENABLE: en_s <= req_data_i.wdata[NUM_IRQ-1:0];
				REG_DISABLE_NUM: en_s[line_n] <= 1'b0;
				REG_ENABLE_NUM: en_s[line_n] <= 1'b1;
				REG_EDGE_SEL: es_s <= req_data_i.wdata[NUM_IRQ-1:0];
				REG_CLEAR_EDGE: clr_s[line_n] <= 1'b1;
				REG_TRIGGER: trg_s[line_n] <= 1'b1;
				default: ;
				endcase
			end
			if (wr_hit || irq_lines_i != prev_s)
				quiet <= '0;
			else if (quiet != 3'd7)
				quiet <= quiet + 3'd1;
			rd_seen <= rd_hit;
			// cause depends on the encoded line, only known once settled
			rd_chk <= rd_hit && (offs != REG_CAUSE || quiet >= 3'd3);
			rd_exp <= exp_rdata;
		end
	end

	// ====================================================================
	// assertions
	// ====================================================================

	// three quiet edges are enough for the request path to settle
	a_level: assert property (@(posedge clk) disable iff (rst_i)
		quiet >= 3'd3 |-> irq_level_o == exp_level)
	else
	begin
		$error("Error %s: irq_level_o expected %0d actual %0d",
			test_name, $sampled(exp_level), $sampled(irq_level_o));
		fail_q = 1'b1;
	end

	a_cause: assert property (@(posedge clk) disable iff (rst_i)
		quiet >= 3'd3 |-> irq_cause_o == exp_cause)
	else
	begin
		$error("Error %s: irq_cause_o expected %0d actual %0d",
			test_name, $sampled(exp_cause), $sampled(irq_cause_o));
		fail_q = 1'b1;
	end

	// nmi follows its input one cycle later, gated by enable bit 0
	a_nmi: assert property (@(posedge clk) disable iff (rst_i)
		!$past(rst_i) |-> nmi_o == $past(nmi_i & en_s[0]))
	else
	begin
		$error("Error %s: nmi_o expected %0b actual %0b",
			test_name, $past(nmi_i & en_s[0]), $sampled(nmi_o));
		fail_q = 1'b1;
	end

	a_rvalid: assert property (@(posedge clk) disable iff (rst_i)
		rvalid_o == rd_seen)
	else
	begin
		$error("Error %s: rvalid_o expected %0b actual %0b",
			test_name, $sampled(rd_seen), $sampled(rvalid_o));
		fail_q = 1'b1;
	end

	a_rdata: assert property (@(posedge clk) disable iff (rst_i)
		rd_chk |-> rdata_o == rd_exp)
	else
	begin
		$error("Error %s: rdata_o expected %08h actual %08h",
			test_name, $sampled(rd_exp), $sampled(rdata_o));
		fail_q = 1'b1;
	end

endmodule

bind pic_top pic_assert #(
	.NUM_IRQ(NUM_IRQ),
	.BASE_ADDR(BASE_ADDR)
) chk (
	.clk(clk),
	.rst_i(rst_i),
	.req_i(req_i),
	.req_data_i(req_data_i),
	.rdata_o(rdata_o),
	.rvalid_o(rvalid_o),
	.irq_lines_i(irq_lines_i),
	.nmi_i(nmi_i),
	.irq_level_o(irq_level_o),
	.irq_cause_o(irq_cause_o),
	.nmi_o(nmi_o)
);

`default_nettype wire

// ==== test/pic_tb.sv ====
`default_nettype none

module pic_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import pic_bus_pkg::*;
	import pic_irq_pkg::*;

	localparam logic [31:0] BASE = 32'hFF95_0000;
	// well above the length of all sequences together
	localparam int unsigned TIMEOUT = 800;

	logic clk;
	logic rst_i;
	logic req_i;
	bus_req_t req_data_i;
	pic_data_t rdata_o;
	logic rvalid_o;
	logic [31:0] irq_lines_i;
	logic nmi_i;
	irq_level_t irq_level_o;
	irq_cause_t irq_cause_o;
	logic nmi_o;

	string test_name = "";
	logic [31:0] seed = 32'd38548;
	int unsigned cycles = 0;
	irq_id_t line;
	logic [31:0] mask;

	pic_top #(
		.NUM_IRQ(32),
		.BASE_ADDR(BASE)
	) dut (
		.clk(clk),
		.rst_i(rst_i),
		.req_i(req_i),
		.req_data_i(req_data_i),
		.rdata_o(rdata_o),
		.rvalid_o(rvalid_o),
		.irq_lines_i(irq_lines_i),
		.nmi_i(nmi_i),
		.irq_level_o(irq_level_o),
		.irq_cause_o(irq_cause_o),
		.nmi_o(nmi_o)
	);

	always #2 clk = ~clk;

	// ====================================================================
	// helpers
	// ====================================================================

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// random line 1..31, line 0 is the nmi
	function automatic irq_id_t pick_line();
		return irq_id_t'(32'd1 + lcg_next() % 32'd31);
	endfunction

	// control word with a random nonzero level and a random cause
	function automatic pic_data_t rand_ctrl_word(input logic en, input logic es);
		irq_level_t lvl;
		irq_cause_t cause;
		lvl = irq_level_t'(32'd1 + lcg_next() % 32'd15);
		cause = irq_cause_t'(lcg_next() >> 16);
		return {14'd0, es, en, 4'd0, lvl, cause};
	endfunction

	function automatic pic_addr_t word_addr(input logic [5:0] offs);
		return BASE + {24'd0, offs, 2'b00};
	endfunction

	// one request cycle, strobe dropped on the next edge
	task automatic bus_access(input logic we, input pic_addr_t addr, input pic_data_t data);
		@(posedge clk);
		req_i <= 1'b1;
		req_data_i <= '{we, addr, data};
		@(posedge clk);
		req_i <= 1'b0;
	endtask

	task automatic wait_cycles(input int unsigned n);
		repeat (n) @(posedge clk);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		dut.chk.test_name = name;
	endtask

	// checker failure or timeout ends the run
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (dut.chk.fail_q)
		begin
			$display("Something failed");
			$fatal(1, "assertion failure in test %s", test_name);
		end
		else if (cycles >= TIMEOUT)
		begin
			$display("Something failed");
			$fatal(1, "simulation timed out after %0d cycles", cycles);
		end
	end

	// ====================================================================
	// sequences
	// ====================================================================

	initial
	begin
		clk = 1'b0;
		rst_i = 1'b1;
		req_i = 1'b0;
		req_data_i = '0;
		irq_lines_i = '0;
		nmi_i = 1'b0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;

		begin_test("reset_state");
		bus_access(1'b0, word_addr(REG_ENABLE), 32'd0);
		bus_access(1'b0, word_addr(REG_EDGE_SEL), 32'd0);
		wait_cycles(4);

		// three random lines in level mode, raised together
		begin_test("level_priority");
		mask = '0;
		for (int i = 0; i < 3; i++)
		begin
			line = pick_line();
			bus_access(1'b1, word_addr({1'b1, line}), rand_ctrl_word(1'b1, 1'b0));
			mask[line] = 1'b1;
		end
		@(posedge clk) irq_lines_i <= mask;
		wait_cycles(6);
		@(posedge clk) irq_lines_i <= '0;
		wait_cycles(6);

		begin_test("enable_mask");
		line = pick_line();
		bus_access(1'b1, word_addr({1'b1, line}), rand_ctrl_word(1'b0, 1'b0));
		@(posedge clk) irq_lines_i <= 32'd1 << line;
		wait_cycles(6);
		bus_access(1'b1, word_addr(REG_ENABLE_NUM), 32'(line));
		wait_cycles(6);
		bus_access(1'b1, word_addr(REG_DISABLE_NUM), 32'(line));
		wait_cycles(6);
		@(posedge clk) irq_lines_i <= '0;
		wait_cycles(4);

		// short pulse stays latched until cleared, trigger sets it again
		begin_test("edge_mode");
		line = pick_line();
		bus_access(1'b1, word_addr({1'b1, line}), rand_ctrl_word(1'b1, 1'b1));
		// an earlier rise in level mode may have left the latch set
		bus_access(1'b1, word_addr(REG_CLEAR_EDGE), 32'(line));
		@(posedge clk) irq_lines_i <= 32'd1 << line;
		@(posedge clk) irq_lines_i <= '0;
		wait_cycles(6);
		bus_access(1'b1, word_addr(REG_CLEAR_EDGE), 32'(line));
		wait_cycles(6);
		bus_access(1'b1, word_addr(REG_TRIGGER), 32'(line));
		wait_cycles(6);
		bus_access(1'b1, word_addr(REG_CLEAR_EDGE), 32'(line));
		wait_cycles(6);

		// nmi toggles while a maskable line is active
		begin_test("nmi");
		@(posedge clk) irq_lines_i <= 32'd1 << line;
		bus_access(1'b1, word_addr(REG_ENABLE_NUM), 32'd0);
		for (int i = 0; i < 8; i++)
			@(posedge clk) nmi_i <= (lcg_next() & 32'h100) != 0;
		bus_access(1'b1, word_addr(REG_DISABLE_NUM), 32'd0);
		for (int i = 0; i < 8; i++)
			@(posedge clk) nmi_i <= (lcg_next() & 32'h100) != 0;
		@(posedge clk) nmi_i <= 1'b0;

		// back-to-back reads over all control words, then offsets 0..7
		begin_test("register_read");
		for (int i = 0; i < 40; i++)
		begin
			@(posedge clk);
			req_i <= 1'b1;
			req_data_i <= '{1'b0, word_addr(6'(i + 32)), 32'd0};
		end
		@(posedge clk) req_i <= 1'b0;
		bus_access(1'b1, word_addr(REG_EDGE_SEL), lcg_next());
		bus_access(1'b0, word_addr(REG_EDGE_SEL), 32'd0);
		// next page up must not answer
		bus_access(1'b1, word_addr(REG_ENABLE) + 32'h1000, '1);
		bus_access(1'b0, word_addr(REG_ENABLE) + 32'h1000, 32'd0);
		bus_access(1'b0, word_addr(REG_ENABLE), 32'd0);
		wait_cycles(6);
		bus_access(1'b0, word_addr(REG_CAUSE), 32'd0);
		wait_cycles(3);

		if (dut.chk.fail_q)
		begin
			$display("Something failed");
			$fatal(1, "assertion failure in test %s", test_name);
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
